//--- files.f
src/ex_ops_pkg.sv
src/ex_stage_pkg.sv
src/ex_alu.sv
src/ex_mult.sv
src/ex_div.sv
src/ex_wb_register.sv
src/ex_stage.sv
test/tb_ex_stage.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_ex_stage
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/tb_ex_stage.sv
// Directed testbench for the execute stage with reference models, checks and watchdog
`timescale 1ns/1ps

module tb_ex_stage import ex_ops_pkg::*, ex_stage_pkg::*;;

  localparam int unsigned SEED = 32'h454a3ea6;
  // 64 ALU, 52 multiply, 24 divide and 4 in the stall and kill tests
  localparam int NUM_INSTR  = 144;
  localparam int WATCHDOG   = NUM_INSTR * 40 + 200;
  localparam int WAIT_LIMIT = 60;

  logic clk;
  logic rst_n;
  logic instr_valid, alu_en, mul_en, div_en, branch;
  alu_op_e alu_op;
  mul_op_e mul_op;
  div_op_e div_op;
  logic [XLEN-1:0] operand_a, operand_b, pc;
  logic rf_we;
  logic [REG_ADDR_W-1:0] rf_waddr;
  logic kill_ex, halt_ex, wb_ready;
  logic ex_ready, ex_valid, branch_decision;
  logic [XLEN-1:0] rf_wdata;
  logic wb_valid, wb_rf_we, wb_bch_taken;
  logic [REG_ADDR_W-1:0] wb_rf_waddr;
  logic [XLEN-1:0] wb_rf_wdata, wb_pc;
  int checks;
  int errors;

  ex_stage i_dut (
    .clk (clk), .rst_n (rst_n), .instr_valid_i (instr_valid),
    .alu_en_i (alu_en), .mul_en_i (mul_en), .div_en_i (div_en), .branch_i (branch),
    .alu_op_i (alu_op), .mul_op_i (mul_op), .div_op_i (div_op),
    .operand_a_i (operand_a), .operand_b_i (operand_b), .rf_we_i (rf_we),
    .rf_waddr_i (rf_waddr), .pc_i (pc), .kill_ex_i (kill_ex), .halt_ex_i (halt_ex),
    .wb_ready_i (wb_ready), .ex_ready_o (ex_ready), .ex_valid_o (ex_valid),
    .branch_decision_o (branch_decision), .rf_wdata_o (rf_wdata),
    .wb_valid_o (wb_valid), .wb_rf_we_o (wb_rf_we), .wb_rf_waddr_o (wb_rf_waddr),
    .wb_rf_wdata_o (wb_rf_wdata), .wb_pc_o (wb_pc), .wb_bch_taken_o (wb_bch_taken)
  );

  // 100 ns period
  always #50 clk = ~clk;

  //////////////////////////////
  // Reference models
  //////////////////////////////

  function automatic logic cmp_model(alu_op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    case (op)
      ALU_EQ:            return a == b;
      ALU_NE:            return a != b;
      ALU_LT, ALU_SLT:   return $signed(a) < $signed(b);
      ALU_GE:            return $signed(a) >= $signed(b);
      ALU_LTU, ALU_SLTU: return a < b;
      ALU_GEU:           return a >= b;
      default:           return 1'b0;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] alu_model(alu_op_e op, logic [XLEN-1:0] a,
                                                logic [XLEN-1:0] b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      ALU_SRA: return $signed(a) >>> b[4:0];
      // Compares give 0 or 1
      default: return {{(XLEN-1){1'b0}}, cmp_model(op, a, b)};
    endcase
  endfunction

  // Full 64-bit product in the signedness of each op
  function automatic logic [XLEN-1:0] mul_model(mul_op_e op, logic [XLEN-1:0] a,
                                                logic [XLEN-1:0] b);
    longint sa, sb, ua, ub;
    logic [63:0] full;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    ua = longint'({32'b0, a});
    ub = longint'({32'b0, b});
    case (op)
      MUL_H:   full = sa * sb;
      MUL_HSU: full = sa * ub;
      default: full = ua * ub;
    endcase
    return (op == MUL_L) ? full[31:0] : full[63:32];
  endfunction

  // Truncating division with the RISC-V zero divisor results
  function automatic logic [XLEN-1:0] div_model(div_op_e op, logic [XLEN-1:0] a,
                                                logic [XLEN-1:0] b);
    longint quo, rem;
    if (b == '0) begin
      quo = -1;
      rem = longint'({32'b0, a});
    end else if (op == DIV_S || op == REM_S) begin
      // Overflow case wraps back to the most negative value
      quo = longint'($signed(a)) / longint'($signed(b));
      rem = longint'($signed(a)) % longint'($signed(b));
    end else begin
      quo = longint'({32'b0, a / b});
      rem = longint'({32'b0, a % b});
    end
    return (op == REM_S || op == REM_U) ? rem[XLEN-1:0] : quo[XLEN-1:0];
  endfunction

  //////////////////////////////
  // Checks and drivers
  //////////////////////////////

  task automatic compare_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail at %t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail at %t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic drive_instr(input logic alu_sel, input logic mul_sel, input logic div_sel,
                             input alu_op_e aop, input mul_op_e mop, input div_op_e dop,
                             input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                             input logic br);
    instr_valid = 1'b1;
    alu_en      = alu_sel;
    mul_en      = mul_sel;
    div_en      = div_sel;
    branch      = br;
    alu_op      = aop;
    mul_op      = mop;
    div_op      = dop;
    operand_a   = a;
    operand_b   = b;
    rf_we       = 1'b1;
    rf_waddr    = REG_ADDR_W'($urandom());
    pc          = $urandom() & 32'hffff_fffc;
  endtask

  task automatic release_instr();
    instr_valid = 1'b0;
    alu_en      = 1'b0;
    mul_en      = 1'b0;
    div_en      = 1'b0;
    branch      = 1'b0;
    rf_we       = 1'b0;
  endtask

  // Counts falling edges until WB shows a valid instruction
  task automatic wait_wb(output int cycles);
    logic seen;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
      seen = wb_valid;
    end
    checks++;
    assert (seen) else begin
      errors++;
      $display("Error at %t: no wb_valid_o within %0d cycles of issue", $time, WAIT_LIMIT);
    end
  endtask

  task automatic issue_and_wait(input logic alu_sel, input logic mul_sel, input logic div_sel,
                                input alu_op_e aop, input mul_op_e mop, input div_op_e dop,
                                input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                                input logic br, input logic [XLEN-1:0] exp_data,
                                input logic exp_taken, output int cycles);
    logic [REG_ADDR_W-1:0] exp_addr;
    logic [XLEN-1:0]       exp_pc;
    @(negedge clk);
    drive_instr(alu_sel, mul_sel, div_sel, aop, mop, dop, a, b, br);
    exp_addr = rf_waddr;
    exp_pc   = pc;
    #1;
    // Forwarded data and branch decision are combinational for the ALU
    if (alu_sel) begin
      compare_word("rf_wdata_o", rf_wdata, exp_data);
      if (br) begin
        compare_bit("branch_decision_o", branch_decision, exp_taken);
      end
    end
    wait_wb(cycles);
    compare_word("wb_rf_wdata_o", wb_rf_wdata, exp_data);
    compare_word("wb_pc_o", wb_pc, exp_pc);
    compare_word("wb_rf_waddr_o", XLEN'(wb_rf_waddr), XLEN'(exp_addr));
    compare_bit("wb_rf_we_o", wb_rf_we, 1'b1);
    compare_bit("wb_bch_taken_o", wb_bch_taken, exp_taken);
    release_instr();
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic reset_check();
    int i;
    rst_n = 1'b0;
    for (i = 0; i <= 16; i++) begin
      // Last pass runs one cycle after release
      if (i == 16) begin
        rst_n = 1'b1;
      end
      @(negedge clk);
      compare_bit("wb_valid_o", wb_valid, 1'b0);
      compare_bit("wb_rf_we_o", wb_rf_we, 1'b0);
      compare_word("wb_rf_wdata_o", wb_rf_wdata, '0);
    end
  endtask

  task automatic alu_sweep();
    alu_op_e op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic br;
    int i;
    int r;
    int cycles;
    for (i = 0; i < 16; i++) begin
      op = alu_op_e'(i[3:0]);
      br = (op >= ALU_EQ);
      for (r = 0; r < 4; r++) begin
        a = $urandom();
        b = $urandom();
        // Equal operands, then opposite signs, then plain random
        if (r == 0) begin
          b = a;
        end else if (r == 1) begin
          a = a | 32'h8000_0000;
          b = b & 32'h7fff_ffff;
        end
        issue_and_wait(1'b1, 1'b0, 1'b0, op, MUL_L, DIV_S, a, b, br,
                       alu_model(op, a, b), br && cmp_model(op, a, b), cycles);
        compare_word("wb_valid_o latency", XLEN'(cycles), 32'd1);
      end
    end
  endtask

  task automatic mul_sweep();
    logic [XLEN-1:0] corners [3];
    mul_op_e op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    int i;
    int r;
    int cycles;
    corners[0] = '0;
    corners[1] = '1;
    corners[2] = 32'h8000_0000;
    for (i = 0; i < 4; i++) begin
      op = mul_op_e'(i[1:0]);
      // All corner pairs first, then random
      for (r = 0; r < 13; r++) begin
        if (r < 9) begin
          a = corners[r / 3];
          b = corners[r % 3];
        end else begin
          a = $urandom();
          b = $urandom();
        end
        issue_and_wait(1'b0, 1'b1, 1'b0, ALU_ADD, op, DIV_S, a, b, 1'b0,
                       mul_model(op, a, b), 1'b0, cycles);
        compare_word("wb_valid_o latency", XLEN'(cycles), 32'd2);
      end
    end
  endtask

  task automatic div_sweep();
    div_op_e op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    int i;
    int r;
    int cycles;
    for (i = 0; i < 4; i++) begin
      op = div_op_e'(i[1:0]);
      for (r = 0; r < 6; r++) begin
        a = $urandom();
        // Varied divisor magnitudes
        b = $urandom() >> ($urandom() % 32);
        if (r == 4) begin
          b = '0;
        end else if (r == 5) begin
          a = 32'h8000_0000;
          b = '1;
        end
        issue_and_wait(1'b0, 1'b0, 1'b1, ALU_ADD, MUL_L, op, a, b, 1'b0,
                       div_model(op, a, b), 1'b0, cycles);
        // Setup, 32 steps and done, or straight to done on a zero divisor
        compare_word("wb_valid_o latency", XLEN'(cycles), (b == '0) ? 32'd2 : 32'd34);
      end
    end
  endtask

  task automatic backpressure_hold();
    logic [XLEN-1:0]       a;
    logic [XLEN-1:0]       b;
    logic [XLEN-1:0]       held_data;
    logic [XLEN-1:0]       held_pc;
    logic [REG_ADDR_W-1:0] held_addr;
    logic [XLEN-1:0]       next_pc;
    logic [REG_ADDR_W-1:0] next_addr;
    int cycles;
    a = $urandom();
    b = $urandom();
    issue_and_wait(1'b1, 1'b0, 1'b0, ALU_ADD, MUL_L, DIV_S, a, b, 1'b0,
                   alu_model(ALU_ADD, a, b), 1'b0, cycles);
    // WB stalls right after the ALU result lands
    wb_ready  = 1'b0;
    held_data = wb_rf_wdata;
    held_pc   = wb_pc;
    held_addr = wb_rf_waddr;
    a = $urandom();
    b = $urandom();
    @(negedge clk);
    drive_instr(1'b0, 1'b1, 1'b0, ALU_ADD, MUL_HU, DIV_S, a, b, 1'b0);
    next_pc   = pc;
    next_addr = rf_waddr;
    repeat (6) begin
      @(negedge clk);
      compare_bit("ex_ready_o", ex_ready, 1'b0);
      compare_bit("wb_valid_o", wb_valid, 1'b1);
      compare_word("wb_rf_wdata_o", wb_rf_wdata, held_data);
      compare_word("wb_pc_o", wb_pc, held_pc);
      compare_word("wb_rf_waddr_o", XLEN'(wb_rf_waddr), XLEN'(held_addr));
    end
    // Product is waiting in the multiplier
    compare_bit("ex_valid_o", ex_valid, 1'b1);
    wb_ready = 1'b1;
    @(negedge clk);
    compare_bit("wb_valid_o", wb_valid, 1'b1);
    compare_word("wb_rf_wdata_o", wb_rf_wdata, mul_model(MUL_HU, a, b));
    compare_word("wb_pc_o", wb_pc, next_pc);
    compare_word("wb_rf_waddr_o", XLEN'(wb_rf_waddr), XLEN'(next_addr));
    release_instr();
  endtask

  task automatic kill_divide();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    int cycles;
    a = $urandom();
    b = $urandom() | 32'd1;
    @(negedge clk);
    drive_instr(1'b0, 1'b0, 1'b1, ALU_ADD, MUL_L, DIV_U, a, b, 1'b0);
    repeat (5) begin
      @(negedge clk);
      compare_bit("ex_ready_o", ex_ready, 1'b0);
      compare_bit("wb_valid_o", wb_valid, 1'b0);
    end
    kill_ex = 1'b1;
    #1;
    // Stage frees up within the same cycle
    compare_bit("ex_ready_o", ex_ready, 1'b1);
    // Divide stays on the inputs well past its normal latency
    repeat (40) begin
      @(negedge clk);
      compare_bit("ex_ready_o", ex_ready, 1'b1);
      compare_bit("ex_valid_o", ex_valid, 1'b0);
      compare_bit("wb_valid_o", wb_valid, 1'b0);
    end
    kill_ex = 1'b0;
    release_instr();
    a = $urandom();
    b = $urandom();
    issue_and_wait(1'b1, 1'b0, 1'b0, ALU_XOR, MUL_L, DIV_S, a, b, 1'b0,
                   alu_model(ALU_XOR, a, b), 1'b0, cycles);
    compare_word("wb_valid_o latency", XLEN'(cycles), 32'd1);
  endtask

  //////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////

  initial begin
    $timeformat(-9, 0, " ns", 0);
    void'($urandom(SEED));
    checks      = 0;
    errors      = 0;
    clk         = 1'b0;
    rst_n       = 1'b0;
    alu_op      = ALU_ADD;
    mul_op      = MUL_L;
    div_op      = DIV_S;
    operand_a   = '0;
    operand_b   = '0;
    rf_waddr    = '0;
    pc          = '0;
    kill_ex     = 1'b0;
    halt_ex     = 1'b0;
    wb_ready    = 1'b1;
    release_instr();
    reset_check();
    alu_sweep();
    mul_sweep();
    div_sweep();
    backpressure_hold();
    kill_divide();
    repeat (2) @(negedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG) @(posedge clk);
    $display("Watchdog expired after %0d cycles, checks: %0d, errors: %0d",
             WATCHDOG, checks, errors);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- src/ex_stage.sv
// Execute stage top with ALU, multiplier, divider, result mux and EX/WB register
`timescale 1ns/1ps

module ex_stage import ex_ops_pkg::*, ex_stage_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  instr_valid_i,
  input  logic                  alu_en_i,
  input  logic                  mul_en_i,
  input  logic                  div_en_i,
  input  logic                  branch_i,
  input  alu_op_e               alu_op_i,
  input  mul_op_e               mul_op_i,
  input  div_op_e               div_op_i,
  input  logic [XLEN-1:0]       operand_a_i,
  input  logic [XLEN-1:0]       operand_b_i,
  input  logic                  rf_we_i,
  input  logic [REG_ADDR_W-1:0] rf_waddr_i,
  input  logic [XLEN-1:0]       pc_i,
  input  logic                  kill_ex_i,
  input  logic                  halt_ex_i,
  input  logic                  wb_ready_i,
  output logic                  ex_ready_o,
  output logic                  ex_valid_o,
  output logic                  branch_decision_o,
  output logic [XLEN-1:0]       rf_wdata_o,
  output logic                  wb_valid_o,
  output logic                  wb_rf_we_o,
  output logic [REG_ADDR_W-1:0] wb_rf_waddr_o,
  output logic [XLEN-1:0]       wb_rf_wdata_o,
  output logic [XLEN-1:0]       wb_pc_o,
  output logic                  wb_bch_taken_o
);

  // Valid with kill and halt removed
  logic            instr_valid;
  logic            mul_en_gated;
  logic            div_en_gated;

  // Unit handshakes and results
  logic            mul_valid;
  logic            mul_ready;
  logic            div_valid;
  logic            div_ready;
  logic [XLEN-1:0] alu_result;
  logic            alu_cmp_result;
  logic [XLEN-1:0] mul_result;
  logic [XLEN-1:0] div_result;
  logic            bch_taken;

  assign instr_valid  = instr_valid_i && !kill_ex_i && !halt_ex_i;
  // Multi-cycle units fall back to idle on kill or halt
  assign mul_en_gated = mul_en_i && instr_valid;
  assign div_en_gated = div_en_i && instr_valid;

  // Forwarded write data, ALU by default
  always_comb begin
    if (mul_en_i) begin
      rf_wdata_o = mul_result;
    end else if (div_en_i) begin
      rf_wdata_o = div_result;
    end else begin
      rf_wdata_o = alu_result;
    end
  end

  assign branch_decision_o = alu_cmp_result;
  assign bch_taken         = branch_i && alu_en_i && alu_cmp_result;

  //////////////////////////////
  // Functional units
  //////////////////////////////

  ex_alu i_alu (
    .operator_i   (alu_op_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  ex_mult i_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .operator_i (mul_op_i),
    .op_a_i     (operand_a_i),
    .op_b_i     (operand_b_i),
    .valid_i    (mul_en_gated),
    .ready_i    (wb_ready_i),
    .valid_o    (mul_valid),
    .ready_o    (mul_ready),
    .result_o   (mul_result)
  );

  ex_div i_div (
    .clk        (clk),
    .rst_n      (rst_n),
    .operator_i (div_op_i),
    .op_a_i     (operand_a_i),
    .op_b_i     (operand_b_i),
    .valid_i    (div_en_gated),
    .ready_i    (wb_ready_i),
    .valid_o    (div_valid),
    .ready_o    (div_ready),
    .result_o   (div_result)
  );

  // ALU is always done in the same cycle
  assign ex_valid_o = instr_valid &&
                      (alu_en_i || (mul_en_i && mul_valid) || (div_en_i && div_valid));

  // Kill empties the stage at once, otherwise every unit and WB must agree
  assign ex_ready_o = kill_ex_i || (mul_ready && div_ready && wb_ready_i && !halt_ex_i);

  //////////////////////////////
  // EX/WB register
  //////////////////////////////

  ex_wb_register i_ex_wb_register (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_valid_i     (ex_valid_o),
    .wb_ready_i     (wb_ready_i),
    .rf_we_i        (rf_we_i),
    .rf_waddr_i     (rf_waddr_i),
    .rf_wdata_i     (rf_wdata_o),
    .pc_i           (pc_i),
    .bch_taken_i    (bch_taken),
    .wb_valid_o     (wb_valid_o),
    .wb_rf_we_o     (wb_rf_we_o),
    .wb_rf_waddr_o  (wb_rf_waddr_o),
    .wb_rf_wdata_o  (wb_rf_wdata_o),
    .wb_pc_o        (wb_pc_o),
    .wb_bch_taken_o (wb_bch_taken_o)
  );

endmodule

//--- src/ex_wb_register.sv
// EX/WB pipeline register with bubble insertion and hold under back-pressure
`timescale 1ns/1ps

module ex_wb_register import ex_ops_pkg::*, ex_stage_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  ex_valid_i,
  input  logic                  wb_ready_i,
  input  logic                  rf_we_i,
  input  logic [REG_ADDR_W-1:0] rf_waddr_i,
  input  logic [XLEN-1:0]       rf_wdata_i,
  input  logic [XLEN-1:0]       pc_i,
  input  logic                  bch_taken_i,
  output logic                  wb_valid_o,
  output logic                  wb_rf_we_o,
  output logic [REG_ADDR_W-1:0] wb_rf_waddr_o,
  output logic [XLEN-1:0]       wb_rf_wdata_o,
  output logic [XLEN-1:0]       wb_pc_o,
  output logic                  wb_bch_taken_o
);

  // Instruction moves into WB only on a full handshake
  logic advance;

  assign advance = ex_valid_i && wb_ready_i;

  //////////////////////////////
  // Pipeline register
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_o     <= 1'b0;
      wb_rf_we_o     <= 1'b0;
      wb_rf_waddr_o  <= '0;
      wb_rf_wdata_o  <= '0;
      wb_pc_o        <= '0;
      wb_bch_taken_o <= 1'b0;
    end else begin
      if (advance) begin
        wb_valid_o     <= 1'b1;
        wb_rf_we_o     <= rf_we_i;
        wb_pc_o        <= pc_i;
        wb_bch_taken_o <= bch_taken_i;
        // Write port fields change only for writing instructions
        if (rf_we_i) begin
          wb_rf_waddr_o <= rf_waddr_i;
          wb_rf_wdata_o <= rf_wdata_i;
        end
      end else if (wb_ready_i) begin
        // WB can take something but EX has nothing, so a bubble
        wb_valid_o <= 1'b0;
      end
      // WB stalled, everything holds
    end
  end

endmodule

//--- src/ex_div.sv
// Iterative restoring divider for signed and unsigned quotient and remainder
`timescale 1ns/1ps

module ex_div import ex_ops_pkg::*, ex_stage_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  div_op_e         operator_i,
  input  logic [XLEN-1:0] op_a_i,
  input  logic [XLEN-1:0] op_b_i,
  input  logic            valid_i,
  input  logic            ready_i,
  output logic            valid_o,
  output logic            ready_o,
  output logic [XLEN-1:0] result_o
);

  // FSM state and iteration counter
  div_state_e           state_q;
  div_state_e           state_d;
  logic [DIV_CNT_W-1:0] cnt_q;

  // Operand preparation
  logic                 is_signed;
  logic                 div_by_zero;
  logic [XLEN-1:0]      abs_a;
  logic [XLEN-1:0]      abs_b;

  // Datapath registers, quotient bits shift in from the right
  logic [XLEN-1:0]      quo_q;
  logic [XLEN-1:0]      rem_q;
  logic [XLEN-1:0]      divisor_q;
  logic                 neg_quo_q;
  logic                 neg_rem_q;

  // One restoring step
  logic [XLEN:0]        shifted_rem;
  logic [XLEN:0]        trial_diff;

  // Sign-corrected results
  logic [XLEN-1:0]      quo_fixed;
  logic [XLEN-1:0]      rem_fixed;

  assign is_signed   = (operator_i == DIV_S) || (operator_i == REM_S);
  assign div_by_zero = (op_b_i == '0);
  assign abs_a       = (is_signed && op_a_i[XLEN-1]) ? -op_a_i : op_a_i;
  assign abs_b       = (is_signed && op_b_i[XLEN-1]) ? -op_b_i : op_b_i;

  assign shifted_rem = {rem_q, quo_q[XLEN-1]};
  assign trial_diff  = shifted_rem - {1'b0, divisor_q};

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      DIV_IDLE: if (valid_i) state_d = div_by_zero ? DIV_DONE : DIV_RUN;
      DIV_RUN:  if (cnt_q == DIV_CNT_W'(1)) state_d = DIV_DONE;
      DIV_DONE: if (ready_i) state_d = DIV_IDLE;
      default:  state_d = DIV_IDLE;
    endcase
    // Dropped request aborts any operation
    if (!valid_i) begin
      state_d = DIV_IDLE;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= DIV_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == DIV_IDLE) begin
        cnt_q <= DIV_CNT_W'(XLEN);
      end else if (state_q == DIV_RUN) begin
        cnt_q <= cnt_q - DIV_CNT_W'(1);
      end
    end
  end

  //////////////////////////////
  // Datapath
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (state_q == DIV_IDLE && valid_i) begin
      if (div_by_zero) begin
        // RISC-V result, all ones quotient and the dividend as remainder
        quo_q     <= '1;
        rem_q     <= op_a_i;
        neg_quo_q <= 1'b0;
        neg_rem_q <= 1'b0;
      end else begin
        // Setup on magnitudes, signs kept for the final fix
        quo_q     <= abs_a;
        rem_q     <= '0;
        divisor_q <= abs_b;
        neg_quo_q <= is_signed && (op_a_i[XLEN-1] ^ op_b_i[XLEN-1]);
        neg_rem_q <= is_signed && op_a_i[XLEN-1];
      end
    end else if (state_q == DIV_RUN) begin
      // Keep the difference only if it did not go negative
      if (!trial_diff[XLEN]) begin
        rem_q <= trial_diff[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b1};
      end else begin
        rem_q <= shifted_rem[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b0};
      end
    end
  end

  // Most negative by minus one gives 0x80000000 with no negation
  assign quo_fixed = neg_quo_q ? -quo_q : quo_q;
  assign rem_fixed = neg_rem_q ? -rem_q : rem_q;

  assign result_o = (operator_i == REM_S || operator_i == REM_U) ? rem_fixed : quo_fixed;

  assign valid_o = (state_q == DIV_DONE);
  assign ready_o = valid_o ? ready_i : !valid_i;

endmodule

//--- src/ex_mult.sv
// Two-step 32x32 multiplier with registered product and half selection
`timescale 1ns/1ps

module ex_mult import ex_ops_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  mul_op_e         operator_i,
  input  logic [XLEN-1:0] op_a_i,
  input  logic [XLEN-1:0] op_b_i,
  input  logic            valid_i,
  input  logic            ready_i,
  output logic            valid_o,
  output logic            ready_o,
  output logic [XLEN-1:0] result_o
);

  // Sign extension bits per operator
  logic                   sign_a;
  logic                   sign_b;
  logic signed [XLEN:0]   op_a_ext;
  logic signed [XLEN:0]   op_b_ext;
  logic signed [2*XLEN+1:0] product;

  // Product register and its valid flag
  logic [2*XLEN-1:0]      product_q;
  logic                   prod_valid_q;

  // MULH treats both signed, MULHSU only a, MULHU and MUL neither
  assign sign_a = (operator_i == MUL_H) || (operator_i == MUL_HSU);
  assign sign_b = (operator_i == MUL_H);

  assign op_a_ext = $signed({sign_a & op_a_i[XLEN-1], op_a_i});
  assign op_b_ext = $signed({sign_b & op_b_i[XLEN-1], op_b_i});
  assign product  = op_a_ext * op_b_ext;

  // Step one, product captured while no result is held
  always_ff @(posedge clk) begin
    if (valid_i && !prod_valid_q) begin
      product_q <= product[2*XLEN-1:0];
    end
  end

  // Result flag drops on an empty input or on acceptance downstream
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prod_valid_q <= 1'b0;
    end else if (!valid_i) begin
      prod_valid_q <= 1'b0;
    end else if (prod_valid_q) begin
      prod_valid_q <= !ready_i;
    end else begin
      prod_valid_q <= 1'b1;
    end
  end

  // Step two, result presented
  assign valid_o = prod_valid_q;

  // Idle is ready only without a pending request
  assign ready_o = prod_valid_q ? ready_i : !valid_i;

  // Low half for MUL, high half for all others
  assign result_o = (operator_i == MUL_L) ? product_q[XLEN-1:0] : product_q[2*XLEN-1:XLEN];

endmodule

//--- src/ex_alu.sv
// Single-cycle ALU with shared adder, comparator and branch decision
`timescale 1ns/1ps

module ex_alu import ex_ops_pkg::*; (
  input  alu_op_e         operator_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,
  output logic [XLEN-1:0] result_o,
  output logic            cmp_result_o
);

  // Shared adder, subtracts for everything except ADD
  logic            sub_mode;
  logic [XLEN-1:0] adder_op_b;
  logic [XLEN:0]   adder_result;

  // Comparison flags
  logic            is_equal;
  logic            less_unsigned;
  logic            less_signed;

  // Shift amount from the low five bits of operand b
  logic [4:0]      shamt;

  assign sub_mode   = (operator_i != ALU_ADD);
  assign adder_op_b = sub_mode ? ~operand_b_i : operand_b_i;

  // Carry in completes the two's complement of operand b
  assign adder_result = {1'b0, operand_a_i} + {1'b0, adder_op_b} + {{XLEN{1'b0}}, sub_mode};

  //////////////////////////////
  // Comparator
  //////////////////////////////

  assign is_equal = (adder_result[XLEN-1:0] == '0);

  // No carry out of a - b means a < b unsigned
  assign less_unsigned = ~adder_result[XLEN];

  // Differing signs decide directly, equal signs fall back to unsigned
  assign less_signed = (operand_a_i[XLEN-1] ^ operand_b_i[XLEN-1]) ?
                       operand_a_i[XLEN-1] : less_unsigned;

  // Branch decision and set-less-than outcome
  always_comb begin
    case (operator_i)
      ALU_EQ:            cmp_result_o = is_equal;
      ALU_NE:            cmp_result_o = ~is_equal;
      ALU_LT, ALU_SLT:   cmp_result_o = less_signed;
      ALU_GE:            cmp_result_o = ~less_signed;
      ALU_LTU, ALU_SLTU: cmp_result_o = less_unsigned;
      ALU_GEU:           cmp_result_o = ~less_unsigned;
      default:           cmp_result_o = 1'b0;
    endcase
  end

  //////////////////////////////
  // Result mux
  //////////////////////////////

  assign shamt = operand_b_i[4:0];

  always_comb begin
    case (operator_i)
      ALU_ADD, ALU_SUB: result_o = adder_result[XLEN-1:0];
      ALU_AND:          result_o = operand_a_i & operand_b_i;
      ALU_OR:           result_o = operand_a_i | operand_b_i;
      ALU_XOR:          result_o = operand_a_i ^ operand_b_i;
      ALU_SLL:          result_o = operand_a_i << shamt;
      ALU_SRL:          result_o = operand_a_i >> shamt;
      ALU_SRA:          result_o = $unsigned($signed(operand_a_i) >>> shamt);
      // Set and compare ops return the zero-extended outcome
      default:          result_o = {{(XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

//--- src/ex_stage_pkg.sv
// Register address width, divider counter width and divider state encoding
package ex_stage_pkg;

  //////////////////////////////
  // Pipeline constants
  //////////////////////////////

  // Register file has 32 entries
  localparam int REG_ADDR_W = 5;

  // Iteration counter must hold the value 32
  localparam int DIV_CNT_W = 6;

  //////////////////////////////
  // Divider FSM
  //////////////////////////////

  // Idle or setup, shift-subtract loop, result presented
  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_RUN,
    DIV_DONE
  } div_state_e;

endpackage

//--- src/ex_ops_pkg.sv
// Data word width and operation encodings for the ALU, multiplier and divider
package ex_ops_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Data word width of the integer pipeline
  localparam int XLEN = 32;

  //////////////////////////////
  // ALU operations
  //////////////////////////////

  // Arithmetic, logic and shift ops first, then set and branch compares
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  // Multiplier ops, low half or one of the three high half variants
  typedef enum logic [1:0] {
    MUL_L,
    MUL_H,
    MUL_HU,
    MUL_HSU
  } mul_op_e;

  // Divider ops, quotient or remainder in signed and unsigned form
  typedef enum logic [1:0] {
    DIV_S,
    DIV_U,
    REM_S,
    REM_U
  } div_op_e;

endpackage
